// ==== logic/raycast_pkg.sv ====
package raycast_pkg;

    // screen geometry
    localparam int SCREEN_WIDTH       = 320;
    localparam int SCREEN_HEIGHT      = 180;
    localparam int HALF_SCREEN_HEIGHT = SCREEN_HEIGHT / 2; // screen centre row
    localparam int GRID_SIDE          = 24;  // cells per grid row
    localparam int MINIMAP_BOUND      = 48;  // minimap is rows and cols below this

    // column word from the dda fifo
    localparam int COLUMN_WORD_W = 38;
    localparam int HCOUNT_LSB    = 29;  // 9 bit screen column
    localparam int HEIGHT_LSB    = 21;  // 8 bit line height
    localparam int WALL_SIDE_BIT = 20;  // 1 = y side hit
    localparam int MAP_LSB       = 16;  // 4 bit map cell value

    typedef logic [8:0]  hcount_t;
    typedef logic [7:0]  vcount_t;
    typedef logic [7:0]  color_t;
    typedef logic [8:0]  ray_pixel_t;  // {shade, colour}
    typedef logic [15:0] fb_addr_t;
    typedef logic [9:0]  grid_addr_t;
    typedef logic [3:0]  map_cell_t;

    // minimap colours
    localparam color_t PLAYER_COLOR     = 8'd98;
    localparam color_t GRID_WALL_COLOR  = 8'd255;
    localparam color_t GRID_EMPTY_COLOR = 8'd18;

    // palette a, map_select 0, 1 and 3
    localparam color_t SKY_A    = 8'h2a;
    localparam color_t GROUND_A = 8'd81;
    localparam color_t WALL_A   = 8'd90;
    // palette b, map_select 2
    localparam color_t SKY_B    = 8'd24;
    localparam color_t GROUND_B = 8'd55;
    localparam color_t WALL_B   = 8'd81;

    // per-row opcode from sweep to shader
    typedef enum logic [2:0] {
        REGION_CEILING,
        REGION_FLOOR,
        REGION_WALL,
        REGION_MINIMAP_CELL,
        REGION_PLAYER
    } region_t;

    typedef enum logic [1:0] {
        WAIT_COLUMN,       // ready for next column word
        WAIT_FRAME_SWITCH, // packet done, hold off until both buffers swap
        SWEEP,             // one row per cycle
        GRID_WAIT          // minimap cell read outstanding
    } sweep_state_t;

endpackage

// ==== logic/column_unpack.sv ====
module column_unpack (
    input  logic                                  pixel_clk_in,
    input  logic                                  rst_in,
    input  logic                                  dda_fifo_tvalid,
    input  logic [raycast_pkg::COLUMN_WORD_W-1:0] dda_fifo_tdata,
    input  logic                                  dda_fifo_tlast,
    input  logic                                  transformer_tready,
    output logic                                  col_load,
    output raycast_pkg::hcount_t                  col_hcount,
    output raycast_pkg::vcount_t                  draw_start,
    output raycast_pkg::vcount_t                  draw_end,
    output logic                                  col_wall_side,
    output raycast_pkg::map_cell_t                col_map,
    output logic                                  col_last
);
    import raycast_pkg::*;

    logic [HCOUNT_LSB-HEIGHT_LSB-1:0] line_height;
    logic [HCOUNT_LSB-HEIGHT_LSB-2:0] half_height;
    vcount_t                          half_clamped;

    // fifo handshake, one strobe per accepted word
    assign col_load = dda_fifo_tvalid && transformer_tready;

    assign line_height = dda_fifo_tdata[HEIGHT_LSB +: (HCOUNT_LSB - HEIGHT_LSB)];
    assign half_height = line_height[HCOUNT_LSB-HEIGHT_LSB-1:1];

    // heights over the screen would wrap draw_start below zero
    always_comb begin
        if (half_height > HALF_SCREEN_HEIGHT) begin
            half_clamped = vcount_t'(HALF_SCREEN_HEIGHT);
        end else begin
            half_clamped = vcount_t'(half_height);
        end
    end

    // field capture, held until the next accept
    always_ff @(posedge pixel_clk_in) begin
        if (col_load) begin
            col_hcount    <= dda_fifo_tdata[HCOUNT_LSB +: $bits(hcount_t)];
            col_wall_side <= dda_fifo_tdata[WALL_SIDE_BIT];
            col_map       <= dda_fifo_tdata[MAP_LSB +: $bits(map_cell_t)];
            draw_start    <= vcount_t'(HALF_SCREEN_HEIGHT) - half_clamped; // first wall row
            draw_end      <= vcount_t'(HALF_SCREEN_HEIGHT) + half_clamped; // first floor row
        end
    end

    // packet end flag steers the sweep fsm, so it gets a reset
    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            col_last <= 1'b0;
        end else if (col_load) begin
            col_last <= dda_fifo_tlast;
        end
    end

endmodule

// ==== logic/column_sweep.sv ====
module column_sweep (
    input  logic                    pixel_clk_in,
    input  logic                    rst_in,
    input  logic                    col_load,
    input  raycast_pkg::hcount_t    col_hcount,
    input  raycast_pkg::vcount_t    draw_start,
    input  raycast_pkg::vcount_t    draw_end,
    input  logic                    col_last,
    input  logic [1:0]              fb_ready_to_switch,
    input  logic [15:0]             pos_x,        // 8.8 grid units
    input  logic [15:0]             pos_y,
    input  logic                    grid_valid,
    input  raycast_pkg::map_cell_t  grid_data,
    output logic                    transformer_tready,
    output logic                    grid_req,
    output raycast_pkg::grid_addr_t grid_address,
    output logic                    issue,
    output raycast_pkg::vcount_t    issue_vcount,
    output raycast_pkg::region_t    issue_region,
    output logic                    issue_grid_wall,
    output logic                    issue_last
);
    import raycast_pkg::*;

    sweep_state_t state;
    vcount_t      row;        // row being classified
    region_t      region;
    logic [7:0]   cell_x;     // minimap is 2x2 pixels per cell
    logic [7:0]   cell_y;
    logic         in_minimap;
    logic         on_player;
    logic         last_row;
    logic         grid_start;
    grid_addr_t   cell_addr;

    assign cell_x = col_hcount[8:1];
    assign cell_y = {1'b0, row[7:1]};

    assign in_minimap = (row < MINIMAP_BOUND) && (col_hcount < MINIMAP_BOUND);
    assign on_player  = (cell_x == pos_x[15:8]) && (cell_y == pos_y[15:8]); // integer part only

    // row-major cell index, max 575 inside the minimap
    assign cell_addr = grid_addr_t'(cell_x) + grid_addr_t'(cell_y) * grid_addr_t'(GRID_SIDE);

    // region priority: minimap, ceiling, floor, wall
    always_comb begin
        if (in_minimap) begin
            if (on_player) begin
                region = REGION_PLAYER;
            end else begin
                region = REGION_MINIMAP_CELL;
            end
        end else if (row < draw_start) begin
            region = REGION_CEILING;
        end else if (row >= draw_end) begin
            region = REGION_FLOOR;
        end else begin
            region = REGION_WALL;
        end
    end

    assign last_row   = (row == vcount_t'(SCREEN_HEIGHT - 1));
    assign grid_start = (state == SWEEP) && (region == REGION_MINIMAP_CELL);

    // minimap cells issue only once the grid answers
    assign issue = ((state == SWEEP) && (region != REGION_MINIMAP_CELL)) ||
                   ((state == GRID_WAIT) && grid_valid);

    assign issue_vcount    = row;
    assign issue_region    = region;
    assign issue_grid_wall = (grid_data != '0);   // only meaningful with grid_valid
    assign issue_last      = issue && col_last && last_row;

    assign transformer_tready = (state == WAIT_COLUMN);

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            state    <= WAIT_COLUMN;
            row      <= '0;
            grid_req <= 1'b0;
        end else begin
            case (state)
                WAIT_COLUMN: begin
                    if (col_load) begin
                        state <= SWEEP; // fields land this edge
                    end
                end
                SWEEP: begin
                    if (grid_start) begin
                        state <= GRID_WAIT;
                    end
                end
                GRID_WAIT: begin
                    state <= GRID_WAIT; // leaves through the row step below
                end
                WAIT_FRAME_SWITCH: begin
                    if (fb_ready_to_switch == 2'd3) begin // both buffers ready
                        state <= WAIT_COLUMN;
                    end
                end
                default: state <= WAIT_COLUMN;
            endcase

            // row step, overrides the state chosen above
            if (issue) begin
                if (last_row) begin
                    row   <= '0;
                    state <= col_last ? WAIT_FRAME_SWITCH : WAIT_COLUMN;
                end else begin
                    row   <= row + 1'b1;
                    state <= SWEEP;
                end
            end

            if (grid_start) begin
                grid_req <= 1'b1;
            end else if ((state == GRID_WAIT) && grid_valid) begin
                grid_req <= 1'b0; // drops the cycle after the data
            end
        end
    end

    // address held steady while the request is up
    always_ff @(posedge pixel_clk_in) begin
        if (grid_start) begin
            grid_address <= cell_addr;
        end
    end

endmodule

// ==== logic/pixel_shader.sv ====
module pixel_shader (
    input  logic                   pixel_clk_in,
    input  logic                   rst_in,
    input  logic                   issue,
    input  raycast_pkg::vcount_t   issue_vcount,
    input  raycast_pkg::region_t   issue_region,
    input  logic                   issue_grid_wall,
    input  logic                   issue_last,
    input  raycast_pkg::hcount_t   col_hcount,
    input  logic                   col_wall_side,
    input  raycast_pkg::map_cell_t col_map,
    input  logic [1:0]             map_select,
    output raycast_pkg::ray_pixel_t ray_pixel,
    output raycast_pkg::fb_addr_t   ray_address,
    output logic                    ray_last_pixel,
    output logic                    pixel_valid
);
    import raycast_pkg::*;

    color_t     sky;
    color_t     ground;
    color_t     wall;
    ray_pixel_t pixel_next;
    fb_addr_t   addr_next;

    // palette select, 3 falls back to the map 0 palette
    always_comb begin
        case (map_select)
            2'd2: begin
                sky    = SKY_B;
                ground = GROUND_B;
                wall   = WALL_B;
            end
            default: begin
                sky    = SKY_A;
                ground = GROUND_A;
                wall   = WALL_A;
            end
        endcase
    end

    // opcode to colour, shade bit set on y-side walls only
    always_comb begin
        case (issue_region)
            REGION_CEILING: pixel_next = {1'b0, sky};
            REGION_FLOOR:   pixel_next = {1'b0, ground};
            REGION_WALL: begin
                if (col_map == '0) begin
                    pixel_next = {1'b0, sky}; // empty cell, see-through
                end else begin
                    pixel_next = {col_wall_side, wall};
                end
            end
            REGION_PLAYER:  pixel_next = {1'b0, PLAYER_COLOR};
            REGION_MINIMAP_CELL: begin
                pixel_next = {1'b0, issue_grid_wall ? GRID_WALL_COLOR : GRID_EMPTY_COLOR};
            end
            default:        pixel_next = {1'b0, sky};
        endcase
    end

    assign addr_next = fb_addr_t'(col_hcount) + fb_addr_t'(issue_vcount) * fb_addr_t'(SCREEN_WIDTH);

    // pixel and address, written only with a valid strobe
    always_ff @(posedge pixel_clk_in) begin
        if (issue) begin
            ray_pixel   <= pixel_next;
            ray_address <= addr_next;
        end
    end

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            pixel_valid    <= 1'b0;
            ray_last_pixel <= 1'b0;
        end else begin
            pixel_valid    <= issue;      // one pulse per row
            ray_last_pixel <= issue_last; // row 179 of a tlast column
        end
    end

endmodule

// ==== logic/column_flattener.sv ====
module column_flattener (
    input  logic                                  pixel_clk_in,
    input  logic                                  rst_in,
    input  logic                                  dda_fifo_tvalid,
    input  logic [raycast_pkg::COLUMN_WORD_W-1:0] dda_fifo_tdata,
    input  logic                                  dda_fifo_tlast,
    input  logic [1:0]                            fb_ready_to_switch,
    input  logic [15:0]                           pos_x,
    input  logic [15:0]                           pos_y,
    input  logic [1:0]                            map_select,
    input  logic                                  grid_valid,
    input  raycast_pkg::map_cell_t                grid_data,
    output logic                                  transformer_tready,
    output logic                                  grid_req,
    output raycast_pkg::grid_addr_t               grid_address,
    output raycast_pkg::ray_pixel_t               ray_pixel,
    output raycast_pkg::fb_addr_t                 ray_address,
    output logic                                  ray_last_pixel,
    output logic                                  pixel_valid
);
    import raycast_pkg::*;

    // decoded column, held through the sweep
    logic      col_load;
    hcount_t   col_hcount;
    vcount_t   draw_start;
    vcount_t   draw_end;
    logic      col_wall_side;
    map_cell_t col_map;
    logic      col_last;

    // per-row opcode into the shader
    logic      issue;
    vcount_t   issue_vcount;
    region_t   issue_region;
    logic      issue_grid_wall;
    logic      issue_last;

    column_unpack u_unpack (
        .pixel_clk_in      (pixel_clk_in),
        .rst_in            (rst_in),
        .dda_fifo_tvalid   (dda_fifo_tvalid),
        .dda_fifo_tdata    (dda_fifo_tdata),
        .dda_fifo_tlast    (dda_fifo_tlast),
        .transformer_tready(transformer_tready),
        .col_load          (col_load),
        .col_hcount        (col_hcount),
        .draw_start        (draw_start),
        .draw_end          (draw_end),
        .col_wall_side     (col_wall_side),
        .col_map           (col_map),
        .col_last          (col_last)
    );

    column_sweep u_sweep (
        .pixel_clk_in      (pixel_clk_in),
        .rst_in            (rst_in),
        .col_load          (col_load),
        .col_hcount        (col_hcount),
        .draw_start        (draw_start),
        .draw_end          (draw_end),
        .col_last          (col_last),
        .fb_ready_to_switch(fb_ready_to_switch),
        .pos_x             (pos_x),
        .pos_y             (pos_y),
        .grid_valid        (grid_valid),
        .grid_data         (grid_data),
        .transformer_tready(transformer_tready),
        .grid_req          (grid_req),
        .grid_address      (grid_address),
        .issue             (issue),
        .issue_vcount      (issue_vcount),
        .issue_region      (issue_region),
        .issue_grid_wall   (issue_grid_wall),
        .issue_last        (issue_last)
    );

    pixel_shader u_shader (
        .pixel_clk_in   (pixel_clk_in),
        .rst_in         (rst_in),
        .issue          (issue),
        .issue_vcount   (issue_vcount),
        .issue_region   (issue_region),
        .issue_grid_wall(issue_grid_wall),
        .issue_last     (issue_last),
        .col_hcount     (col_hcount),
        .col_wall_side  (col_wall_side),
        .col_map        (col_map),
        .map_select     (map_select),
        .ray_pixel      (ray_pixel),
        .ray_address    (ray_address),
        .ray_last_pixel (ray_last_pixel),
        .pixel_valid    (pixel_valid)
    );

endmodule

// ==== verif/clock_gen.sv ====
module clock_gen (
    output logic pixel_clk_in,
    output logic rst_in
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        pixel_clk_in = 1'b0;
        forever #20 pixel_clk_in = ~pixel_clk_in; // 40 ns period
    end

    initial begin
        rst_in = 1'b1;
        repeat (8) @(posedge pixel_clk_in);
        rst_in <= 1'b0; // released on an edge like all other inputs
    end
endmodule

// ==== verif/pixel_checker.sv ====
module pixel_checker (
    input  logic                    pixel_clk_in,
    input  logic                    rst_in,
    input  logic                    dda_fifo_tvalid,
    input  logic [37:0]             dda_fifo_tdata,
    input  logic                    dda_fifo_tlast,
    input  logic                    transformer_tready,
    input  logic [1:0]              fb_ready_to_switch,
    input  logic [15:0]             pos_x,
    input  logic [15:0]             pos_y,
    input  logic [1:0]              map_select,
    input  logic                    grid_req,
    input  logic                    grid_valid,
    input  raycast_pkg::grid_addr_t grid_address,
    input  raycast_pkg::ray_pixel_t ray_pixel,
    input  raycast_pkg::fb_addr_t   ray_address,
    input  logic                    ray_last_pixel,
    input  logic                    pixel_valid,
    input  logic                    test_end,
    input  int                      test_id,
    input  logic                    report_end,
    output int                      columns_done,
    output int                      error_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import raycast_pkg::*;

    typedef struct packed {
        logic [8:0]  hcount;
        logic [7:0]  height;
        logic        side;
        logic [3:0]  map;
        logic        last;
        logic [1:0]  sel;   // palette and player latched at accept
        logic [15:0] px;
        logic [15:0] py;
    } column_t;

    column_t col_q[$];
    column_t cur;
    int      row_idx = 0;        // rows seen of the front column
    int      test_errors = 0;
    int      test_pixels = 0;
    int      tests_passed = 0;
    int      tests_failed = 0;
    logic    frame_hold = 1'b0;  // tlast column done, no intake allowed

    initial columns_done = 0;
    initial error_count = 0;

    function automatic ray_pixel_t expected_pixel(column_t c, int row);
        int     half;
        int     cx;
        int     cy;
        color_t sky;
        color_t ground;
        color_t wall;
        half = c.height / 2;
        if (half > HALF_SCREEN_HEIGHT) half = HALF_SCREEN_HEIGHT; // tall lines fill the column
        sky    = (c.sel == 2'd2) ? SKY_B : SKY_A;
        ground = (c.sel == 2'd2) ? GROUND_B : GROUND_A;
        wall   = (c.sel == 2'd2) ? WALL_B : WALL_A;
        cx = c.hcount / 2;
        cy = row / 2;
        if (row < MINIMAP_BOUND && c.hcount < MINIMAP_BOUND) begin
            if (cx == c.px[15:8] && cy == c.py[15:8]) return {1'b0, PLAYER_COLOR};
            // grid model answers address mod 3
            if (((cx + cy * GRID_SIDE) % 3) != 0) return {1'b0, GRID_WALL_COLOR};
            return {1'b0, GRID_EMPTY_COLOR};
        end
        if (row < HALF_SCREEN_HEIGHT - half) return {1'b0, sky};
        if (row >= HALF_SCREEN_HEIGHT + half) return {1'b0, ground};
        if (c.map == 4'd0) return {1'b0, sky};
        return {c.side, wall};
    endfunction

    task automatic value_error(string what, int exp, int got);
        $display("** Error @ %0t: %s expected %0h got %0h", $time, what, exp, got);
        error_count++;
        test_errors++;
    endtask

    task automatic problem(string msg);
        $display("%0t: %s", $time, msg);
        error_count++;
        test_errors++;
    endtask

    always @(posedge pixel_clk_in) begin
        if (!rst_in) begin
            if (fb_ready_to_switch == 2'd3) frame_hold = 1'b0;
            if (ray_last_pixel && !pixel_valid) problem("ray_last_pixel without pixel_valid");

            if (pixel_valid && col_q.size() == 0) begin
                problem("pixel_valid with no accepted column");
            end else if (pixel_valid) begin
                cur = col_q[0];
                test_pixels++;
                if (ray_pixel != expected_pixel(cur, row_idx))
                    value_error($sformatf("pixel col %0d row %0d", cur.hcount, row_idx),
                                expected_pixel(cur, row_idx), ray_pixel);
                if (ray_address != cur.hcount + row_idx * SCREEN_WIDTH)
                    value_error("address", cur.hcount + row_idx * SCREEN_WIDTH, ray_address);
                if (ray_last_pixel != (cur.last && row_idx == SCREEN_HEIGHT - 1))
                    value_error("last flag", cur.last && row_idx == SCREEN_HEIGHT - 1,
                                ray_last_pixel);
                if (row_idx == SCREEN_HEIGHT - 1) begin
                    // plain column reopens intake at once, tlast one holds it
                    if (transformer_tready != !cur.last)
                        value_error("tready after column", !cur.last, transformer_tready);
                    if (cur.last) frame_hold = 1'b1;
                    void'(col_q.pop_front());
                    row_idx = 0;
                    columns_done <= columns_done + 1;
                end else begin
                    row_idx++;
                end
            end

            if (grid_req && grid_valid) begin
                if (col_q.size() == 0) begin
                    problem("grid read with no column in flight");
                end else begin
                    cur = col_q[0];
                    if (expected_pixel(cur, row_idx) == {1'b0, PLAYER_COLOR} ||
                        row_idx >= MINIMAP_BOUND || cur.hcount >= MINIMAP_BOUND)
                        problem("grid read on a row that needs none");
                    else if (grid_address != cur.hcount / 2 + (row_idx / 2) * GRID_SIDE)
                        value_error("grid address", cur.hcount / 2 + (row_idx / 2) * GRID_SIDE,
                                    grid_address);
                end
            end

            if (dda_fifo_tvalid && transformer_tready) begin
                if (frame_hold) problem("column accepted before the frame switch");
                col_q.push_back({dda_fifo_tdata[37:29], dda_fifo_tdata[28:21],
                                 dda_fifo_tdata[20], dda_fifo_tdata[19:16], dda_fifo_tlast,
                                 map_select, pos_x, pos_y});
            end

            if (test_end) begin
                if (col_q.size() != 0 || row_idx != 0) problem("column left incomplete");
                $display("test %0d: %s, %0d pixels, %0d errors", test_id,
                         (test_errors == 0) ? "PASS" : "FAIL", test_pixels, test_errors);
                if (test_errors == 0) tests_passed++;
                else tests_failed++;
                test_errors = 0;
                test_pixels = 0;
            end
            if (report_end)
                $display("summary: %0d passed, %0d failed, %0d errors", tests_passed,
                         tests_failed, error_count);
        end
    end
endmodule

// ==== verif/column_flattener_assertions.sv ====
module column_flattener_assertions (
    input logic                      pixel_clk_in,
    input logic                      rst_in,
    input raycast_pkg::sweep_state_t state,
    input logic                      col_load,
    input logic [1:0]                fb_ready_to_switch,
    input logic                      transformer_tready,
    input logic                      grid_req,
    input logic                      grid_valid,
    input logic                      issue,
    input raycast_pkg::vcount_t      issue_vcount
);
    timeunit 1ns;
    timeprecision 1ps;
    import raycast_pkg::*;

    // no intake reopens until the last row of the column is out
    tready_low_in_sweep: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        ((state == SWEEP || state == GRID_WAIT) &&
         !(issue && issue_vcount == vcount_t'(SCREEN_HEIGHT - 1))) |=> !transformer_tready)
        else $error("tready rose before the last row");

    // request is a level until the grid answers
    grid_req_held: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        (grid_req && !grid_valid) |=> grid_req)
        else $error("grid_req dropped before grid_valid");

    // a wait state holds until its own trigger
    no_issue_when_waiting: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        ((state == WAIT_COLUMN && !col_load) ||
         (state == WAIT_FRAME_SWITCH && fb_ready_to_switch != 2'd3)) |=> !issue)
        else $error("row issued in a wait state");
endmodule

bind column_sweep column_flattener_assertions u_sweep_assertions (
    .pixel_clk_in(pixel_clk_in), .rst_in(rst_in), .state(state), .col_load(col_load),
    .fb_ready_to_switch(fb_ready_to_switch), .transformer_tready(transformer_tready),
    .grid_req(grid_req), .grid_valid(grid_valid), .issue(issue),
    .issue_vcount(issue_vcount)
);

// ==== verif/tb_column_flattener.sv ====
module tb_column_flattener;
    timeunit 1ns;
    timeprecision 1ps;
    import raycast_pkg::*;

    localparam int NUM_COLUMNS = 23;
    localparam longint WATCHDOG_NS = NUM_COLUMNS * SCREEN_HEIGHT * 5 * 40 + 10000;

    logic pixel_clk_in, rst_in;
    logic dda_fifo_tvalid = 1'b0, dda_fifo_tlast = 1'b0;
    logic [COLUMN_WORD_W-1:0] dda_fifo_tdata = '0;
    logic [1:0] fb_ready_to_switch = 2'd0, map_select = 2'd0;
    logic [15:0] pos_x = 16'h1400, pos_y = 16'h1400; // player cell kept until the minimap test
    logic grid_valid = 1'b0;
    map_cell_t grid_data = '0;
    logic transformer_tready, grid_req, ray_last_pixel, pixel_valid;
    grid_addr_t grid_address;
    ray_pixel_t ray_pixel;
    fb_addr_t ray_address;
    logic test_end = 1'b0, report_end = 1'b0;
    int test_id = 0, columns_sent = 0, columns_done, error_count;
    int unsigned stim_rng = 30, grid_rng = 30, fb_rng = 30;
    int grid_wait = 0, fb_wait = 0;
    logic grid_pending = 1'b0, fb_pending = 1'b0;
    int heights[6] = '{0, 1, 60, 179, 180, 250};

    clock_gen u_clock (.pixel_clk_in(pixel_clk_in), .rst_in(rst_in));

    column_flattener DUT (.*);

    pixel_checker u_checker (.*);

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic send_column(input int hc, input int ht, input bit side, input int map,
                               input bit last);
        stim_rng = lcg_next(stim_rng);
        @(posedge pixel_clk_in);
        dda_fifo_tvalid <= 1'b1;
        dda_fifo_tlast  <= last;
        dda_fifo_tdata  <= {9'(hc), 8'(ht), side, 4'(map), stim_rng[23:8]}; // low bits unused
        do @(posedge pixel_clk_in); while (!transformer_tready); // word held until accept
        dda_fifo_tvalid <= 1'b0;
        columns_sent++;
    endtask

    task automatic finish_test(input int id);
        while (columns_done != columns_sent) @(posedge pixel_clk_in);
        test_id  <= id;
        test_end <= 1'b1;
        @(posedge pixel_clk_in);
        test_end <= 1'b0;
    endtask

    // grid memory, 1 to 3 cycles latency, data is address mod 3
    always @(posedge pixel_clk_in) begin
        if (grid_valid) begin
            grid_valid   <= 1'b0;
            grid_pending <= 1'b0;
        end else if (grid_req && !grid_pending) begin
            grid_rng     <= lcg_next(grid_rng);
            grid_wait    <= grid_rng[17:16] % 3;
            grid_pending <= 1'b1;
        end else if (grid_pending && grid_wait == 0) begin
            grid_valid <= 1'b1;
            grid_data  <= map_cell_t'(grid_address % 3);
        end else if (grid_pending) begin
            grid_wait <= grid_wait - 1;
        end
    end

    // frame buffer swap some cycles after each packet end
    always @(posedge pixel_clk_in) begin
        if (fb_ready_to_switch != 2'd0) begin
            fb_ready_to_switch <= 2'd0;
        end else if (ray_last_pixel) begin
            fb_rng     <= lcg_next(fb_rng);
            fb_wait    <= 2 + fb_rng[18:16];
            fb_pending <= 1'b1;
        end else if (fb_pending && fb_wait == 0) begin
            fb_ready_to_switch <= 2'd3;
            fb_pending         <= 1'b0;
        end else if (fb_pending) begin
            fb_wait <= fb_wait - 1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, the DUT stopped producing pixels", $time);
        $display("tests failed");
        $finish;
    end

    initial begin
        @(negedge rst_in);
        @(posedge pixel_clk_in);
        foreach (heights[i]) send_column(100 + i, heights[i], i % 2, 1, 1'b0); // boundaries
        finish_test(1);
        for (int i = 0; i < 4; i++) begin // shading and see-through cells
            stim_rng = lcg_next(stim_rng);
            send_column(48 + stim_rng[24:16] % 272, 80 + stim_rng[7:0] % 100, i % 2,
                        (i < 2) ? 0 : 1 + stim_rng[11:8] % 15, 1'b0);
        end
        finish_test(2);
        for (int s = 0; s < 4; s++) begin // every palette select
            map_select <= 2'(s);
            stim_rng = lcg_next(stim_rng);
            send_column(200, 40 + stim_rng[23:16] % 140, stim_rng[5], 3, 1'b0);
            while (columns_done != columns_sent) @(posedge pixel_clk_in);
        end
        finish_test(3);
        map_select <= 2'd0;
        stim_rng = lcg_next(stim_rng);
        pos_x <= {8'd5, stim_rng[15:8]}; // player cell 5,10
        pos_y <= {8'd10, stim_rng[23:16]};
        send_column(10, 120, 1'b0, 2, 1'b0);
        send_column(11, 30, 1'b1, 2, 1'b0);
        send_column(0, 200, 1'b1, 7, 1'b0);
        send_column(47, 90, 1'b0, 0, 1'b0);
        finish_test(4);
        send_column(60, 100, 1'b0, 1, 1'b0); // packet end and frame switch wait
        send_column(61, 110, 1'b1, 1, 1'b0);
        send_column(62, 120, 1'b0, 1, 1'b1);
        send_column(63, 130, 1'b1, 1, 1'b0);
        send_column(64, 140, 1'b0, 1, 1'b1);
        finish_test(5);
        report_end <= 1'b1;
        @(posedge pixel_clk_in);
        report_end <= 1'b0;
        @(posedge pixel_clk_in);
        if (error_count == 0) $display("all tests passed");
        else $display("tests failed");
        $finish;
    end
endmodule

// ==== build.f ====
logic/raycast_pkg.sv
logic/column_unpack.sv
logic/column_sweep.sv
logic/pixel_shader.sv
logic/column_flattener.sv
verif/clock_gen.sv
verif/pixel_checker.sv
verif/column_flattener_assertions.sv
verif/tb_column_flattener.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the column flattener testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_column_flattener -o tb_sim > build.log 2>&1 ||
    { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || echo "tests failed" >> sim.log
cat sim.log

grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
